// ==== src/core_pkg.sv ====
`default_nettype none

package core_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the RV32I subset this core executes
    typedef enum logic [6:0] {
        OP_RTYPE  = 7'b0110011,
        OP_ITYPE  = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_JALR   = 7'b1100111,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // ALU funct3 codes, where SUB shares ADD and is told apart by funct7 bit 5
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // only word accesses exist
    localparam logic [2:0] F3_LW_SW   = 3'b010;

    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;

    // everything execute needs from decode
    typedef struct packed {
        logic       valid;
        opcode_e    opcode;
        logic [2:0] funct3;
        logic       funct7_b5;
        reg_idx_t   rd;
        xlen_t      op_a;
        xlen_t      op_b;
        xlen_t      imm;
        xlen_t      pc;
    } id_ex_t;

endpackage

`default_nettype wire

// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] mem_word_t;

    // one request format for host, data and fetch clients
    typedef struct packed {
        logic      req;
        logic      we;
        addr_t     addr;
        mem_word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== src/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  core_pkg::reg_idx_t id_rs1,
    input  core_pkg::reg_idx_t id_rs2,
    input  logic [6:0]         opcode,
    input  core_pkg::reg_idx_t ex_rd,
    input  logic               ex_load_inst,
    input  logic               jump_branch_taken,
    input  logic               invalid_inst,
    input  logic               stall,
    output logic               if_id_pipeline_flush,
    output logic               if_id_pipeline_en,
    output logic               id_ex_pipeline_flush,
    output logic               pc_en,
    output logic               load_stall
);

    import core_pkg::*;

    logic id_rs1_used;
    logic id_rs2_used;
    logic load_use;

    // JAL reads no register, so it can never wait on a load
    assign id_rs1_used = opcode == OP_RTYPE || opcode == OP_ITYPE || opcode == OP_LOAD ||
                         opcode == OP_JALR || opcode == OP_STORE || opcode == OP_BRANCH;
    assign id_rs2_used = opcode == OP_RTYPE || opcode == OP_STORE || opcode == OP_BRANCH;

    assign load_use = ex_load_inst && ex_rd != '0 &&
                      ((id_rs1_used && id_rs1 == ex_rd) || (id_rs2_used && id_rs2 == ex_rd));

    always_comb begin
        if_id_pipeline_flush = 1'b0;
        if_id_pipeline_en    = 1'b1;
        id_ex_pipeline_flush = 1'b0;
        pc_en                = 1'b1;
        load_stall           = 1'b0;

        if (jump_branch_taken) begin
            // drop the two younger instructions, the pc takes the target
            if_id_pipeline_flush = 1'b1;
            if_id_pipeline_en    = 1'b0;
            id_ex_pipeline_flush = 1'b1;
        end else if (load_use) begin
            // hold fetch and decode for one cycle until the load has written back
            if_id_pipeline_en    = 1'b0;
            id_ex_pipeline_flush = 1'b1;
            pc_en                = 1'b0;
            load_stall           = 1'b1;
        end else if (invalid_inst) begin
            id_ex_pipeline_flush = 1'b1;
        end else if (stall) begin
            // fetch lost the memory, so decode repeats next cycle behind a bubble
            if_id_pipeline_en    = 1'b0;
            id_ex_pipeline_flush = 1'b1;
            pc_en                = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter mem_pkg::addr_t RESET_PC = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pc_en,
    input  logic               if_id_pipeline_en,
    input  logic               if_id_pipeline_flush,
    input  logic               jump_branch_taken,
    input  mem_pkg::addr_t     branch_target,
    input  logic               fetch_grant,
    input  mem_pkg::mem_word_t rdata,
    output mem_pkg::mem_req_t  fetch_req,
    output logic               if_id_valid,
    output mem_pkg::mem_word_t if_id_instr,
    output mem_pkg::addr_t     if_id_pc,
    output logic               fetch_granted
);

    import mem_pkg::*;

    addr_t pc;
    logic  fetch_en;

    // fetch starts one cycle after reset so the host owns memory until then
    assign fetch_req     = '{req: fetch_en, we: 1'b0, addr: pc, wdata: '0};
    assign fetch_granted = fetch_grant;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_en    <= 1'b0;
            pc          <= RESET_PC;
            if_id_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            // the pc only moves past a word that was actually read
            if (jump_branch_taken) begin
                pc <= branch_target;
            end else if (pc_en && fetch_granted) begin
                pc <= pc + 32'd4;
            end
            if (if_id_pipeline_flush) begin
                if_id_valid <= 1'b0;
            end else if (if_id_pipeline_en) begin
                if_id_valid <= fetch_granted;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (if_id_pipeline_en && fetch_granted) begin
            if_id_instr <= rdata;
            if_id_pc    <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== src/decode_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               if_id_valid,
    input  core_pkg::xlen_t    if_id_instr,
    input  core_pkg::xlen_t    if_id_pc,
    input  logic               id_ex_pipeline_flush,
    input  logic               ex_fwd_valid,
    input  core_pkg::reg_idx_t ex_fwd_rd,
    input  core_pkg::xlen_t    ex_fwd_data,
    input  logic               wb_valid,
    input  core_pkg::reg_idx_t wb_rd,
    input  core_pkg::xlen_t    wb_data,
    output core_pkg::reg_idx_t id_rs1,
    output core_pkg::reg_idx_t id_rs2,
    output logic [6:0]         opcode,
    output logic               invalid_inst,
    output core_pkg::id_ex_t   id_ex
);

    import core_pkg::*;

    xlen_t      regs [32];
    logic [2:0] funct3;
    logic       known_op;
    xlen_t      imm;
    id_ex_t     id_ex_d;

    assign opcode = if_id_instr[6:0];
    assign funct3 = if_id_instr[14:12];
    assign id_rs1 = if_id_instr[19:15];
    assign id_rs2 = if_id_instr[24:20];

    // **************************************************
    // register file with forwarding
    // **************************************************

    // the EX result is newer than the one being written back, so it wins
    function automatic xlen_t read_reg(input reg_idx_t idx);
        xlen_t val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_fwd_valid && ex_fwd_rd == idx) begin
            val = ex_fwd_data;
        end else if (wb_valid && wb_rd == idx) begin
            val = wb_data;
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // **************************************************
    // field decode
    // **************************************************

    // byte and halfword accesses count as unknown
    always_comb begin
        case (opcode)
            OP_RTYPE, OP_ITYPE, OP_JALR, OP_BRANCH, OP_JAL: known_op = 1'b1;
            OP_LOAD, OP_STORE: known_op = funct3 == F3_LW_SW;
            default: known_op = 1'b0;
        endcase
    end

    assign invalid_inst = if_id_valid && !known_op;

    always_comb begin
        case (opcode)
            OP_STORE: imm = {{20{if_id_instr[31]}}, if_id_instr[31:25], if_id_instr[11:7]};
            OP_BRANCH: imm = {{19{if_id_instr[31]}}, if_id_instr[31], if_id_instr[7],
                              if_id_instr[30:25], if_id_instr[11:8], 1'b0};
            OP_JAL: imm = {{11{if_id_instr[31]}}, if_id_instr[31], if_id_instr[19:12],
                           if_id_instr[20], if_id_instr[30:21], 1'b0};
            default: imm = {{20{if_id_instr[31]}}, if_id_instr[31:20]};
        endcase
    end

    always_comb begin
        id_ex_d.valid     = if_id_valid && !id_ex_pipeline_flush;
        id_ex_d.opcode    = opcode_e'(opcode);
        id_ex_d.funct3    = funct3;
        id_ex_d.funct7_b5 = if_id_instr[30];
        id_ex_d.rd        = if_id_instr[11:7];
        id_ex_d.op_a      = read_reg(id_rs1);
        id_ex_d.op_b      = read_reg(id_rs2);
        id_ex_d.imm       = imm;
        id_ex_d.pc        = if_id_pc;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else begin
            id_ex <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::id_ex_t   id_ex,
    input  logic               data_grant,
    input  mem_pkg::mem_word_t rdata,
    output mem_pkg::mem_req_t  data_req,
    output core_pkg::reg_idx_t ex_rd,
    output logic               ex_load_inst,
    output logic               ex_fwd_valid,
    output core_pkg::xlen_t    ex_fwd_data,
    output logic               jump_branch_taken,
    output mem_pkg::addr_t     branch_target,
    output logic               wb_valid,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::xlen_t    wb_data
);

    import core_pkg::*;
    import mem_pkg::*;

    logic  is_load;
    logic  is_store;
    logic  is_jump;
    logic  writes_rd;
    logic  branch_cond;
    xlen_t alu_b;
    xlen_t alu_out;
    xlen_t result;

    assign is_load   = id_ex.valid && id_ex.opcode == OP_LOAD;
    assign is_store  = id_ex.valid && id_ex.opcode == OP_STORE;
    assign is_jump   = id_ex.opcode == OP_JAL || id_ex.opcode == OP_JALR;
    assign writes_rd = id_ex.valid && id_ex.rd != '0 &&
                       (id_ex.opcode == OP_RTYPE || id_ex.opcode == OP_ITYPE || is_jump ||
                        id_ex.opcode == OP_LOAD);

    // the adder also forms load, store and JALR addresses
    assign alu_b = (id_ex.opcode == OP_RTYPE) ? id_ex.op_b : id_ex.imm;

    always_comb begin
        case (id_ex.funct3)
            F3_OR:  alu_out = id_ex.op_a | alu_b;
            F3_AND: alu_out = id_ex.op_a & alu_b;
            default: begin
                if (id_ex.opcode == OP_RTYPE && id_ex.funct3 == F3_ADD_SUB && id_ex.funct7_b5) begin
                    alu_out = id_ex.op_a - alu_b;
                end else begin
                    alu_out = id_ex.op_a + alu_b;
                end
            end
        endcase
    end

    always_comb begin
        case (id_ex.funct3)
            F3_BEQ:  branch_cond = id_ex.op_a == id_ex.op_b;
            F3_BNE:  branch_cond = id_ex.op_a != id_ex.op_b;
            default: branch_cond = 1'b0;
        endcase
    end

    // jumps link pc+4 into rd
    assign result = is_jump ? id_ex.pc + 32'd4 : alu_out;

    assign jump_branch_taken = id_ex.valid &&
                               (is_jump || (id_ex.opcode == OP_BRANCH && branch_cond));
    assign branch_target     = (id_ex.opcode == OP_JALR) ? {alu_out[31:1], 1'b0}
                                                         : id_ex.pc + id_ex.imm;

    assign data_req = '{req: is_load || is_store, we: is_store, addr: alu_out,
                        wdata: id_ex.op_b};

    // load data only arrives in writeback, so loads are never forwarded from here
    assign ex_rd        = id_ex.rd;
    assign ex_load_inst = is_load;
    assign ex_fwd_valid = writes_rd && !is_load;
    assign ex_fwd_data  = result;

    // a load that loses the memory to the host retires without a result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= writes_rd && (!is_load || data_grant);
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= id_ex.rd;
        wb_data <= is_load ? rdata : result;
    end

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  mem_pkg::mem_req_t host_req,
    input  mem_pkg::mem_req_t data_req,
    input  mem_pkg::mem_req_t fetch_req,
    output logic              host_grant,
    output logic              data_grant,
    output logic              fetch_grant,
    output mem_pkg::mem_req_t mem_req
);

    // host first, then data, then fetch
    assign host_grant  = host_req.req;
    assign data_grant  = data_req.req && !host_req.req;
    assign fetch_grant = fetch_req.req && !host_req.req && !data_req.req;

    always_comb begin
        if (host_grant) begin
            mem_req = host_req;
        end else if (data_grant) begin
            mem_req = data_req;
        end else if (fetch_grant) begin
            mem_req = fetch_req;
        end else begin
            mem_req = '0;
        end
    end

endmodule

`default_nettype wire

// ==== src/unified_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module unified_mem #(
    parameter int MEM_WORDS = 256
) (
    input  logic               clk,
    input  mem_pkg::mem_req_t  mem_req,
    output mem_pkg::mem_word_t rdata
);

    import mem_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    mem_word_t     mem [MEM_WORDS];
    logic [AW-1:0] word_idx;

    // byte address bits 1:0 are ignored, higher bits wrap around the array
    assign word_idx = mem_req.addr[AW+1:2];
    assign rdata    = mem[word_idx];

    always_ff @(posedge clk) begin
        if (mem_req.req && mem_req.we) begin
            mem[word_idx] <= mem_req.wdata;
        end
    end

endmodule

`default_nettype wire

// ==== src/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter int             MEM_WORDS = 256,
    parameter mem_pkg::addr_t RESET_PC  = 32'h0000_0000
) (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::mem_req_t  host_req,
    output mem_pkg::mem_word_t rdata,
    output logic               wb_valid,
    output core_pkg::reg_idx_t wb_rd,
    output core_pkg::xlen_t    wb_data,
    output logic               load_stall
);

    import core_pkg::*;
    import mem_pkg::*;

    // **************************************************
    // pipeline interconnect
    // **************************************************

    mem_req_t  fetch_req;
    mem_req_t  data_req;
    mem_req_t  mem_req;
    logic      fetch_grant;
    logic      data_grant;
    logic      fetch_granted;
    logic      if_id_valid;
    mem_word_t if_id_instr;
    addr_t     if_id_pc;
    logic      pc_en;
    logic      if_id_pipeline_en;
    logic      if_id_pipeline_flush;
    logic      id_ex_pipeline_flush;
    reg_idx_t  id_rs1;
    reg_idx_t  id_rs2;
    logic [6:0] opcode;
    logic      invalid_inst;
    id_ex_t    id_ex;
    reg_idx_t  ex_rd;
    logic      ex_load_inst;
    logic      ex_fwd_valid;
    xlen_t     ex_fwd_data;
    logic      jump_branch_taken;
    addr_t     branch_target;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk                 (clk),
        .rst_n               (rst_n),
        .pc_en               (pc_en),
        .if_id_pipeline_en   (if_id_pipeline_en),
        .if_id_pipeline_flush(if_id_pipeline_flush),
        .jump_branch_taken   (jump_branch_taken),
        .branch_target       (branch_target),
        .fetch_grant         (fetch_grant),
        .rdata               (rdata),
        .fetch_req           (fetch_req),
        .if_id_valid         (if_id_valid),
        .if_id_instr         (if_id_instr),
        .if_id_pc            (if_id_pc),
        .fetch_granted       (fetch_granted)
    );

    decode_unit u_decode (
        .clk                 (clk),
        .rst_n               (rst_n),
        .if_id_valid         (if_id_valid),
        .if_id_instr         (if_id_instr),
        .if_id_pc            (if_id_pc),
        .id_ex_pipeline_flush(id_ex_pipeline_flush),
        .ex_fwd_valid        (ex_fwd_valid),
        .ex_fwd_rd           (ex_rd),
        .ex_fwd_data         (ex_fwd_data),
        .wb_valid            (wb_valid),
        .wb_rd               (wb_rd),
        .wb_data             (wb_data),
        .id_rs1              (id_rs1),
        .id_rs2              (id_rs2),
        .opcode              (opcode),
        .invalid_inst        (invalid_inst),
        .id_ex               (id_ex)
    );

    execute_unit u_execute (
        .clk              (clk),
        .rst_n            (rst_n),
        .id_ex            (id_ex),
        .data_grant       (data_grant),
        .rdata            (rdata),
        .data_req         (data_req),
        .ex_rd            (ex_rd),
        .ex_load_inst     (ex_load_inst),
        .ex_fwd_valid     (ex_fwd_valid),
        .ex_fwd_data      (ex_fwd_data),
        .jump_branch_taken(jump_branch_taken),
        .branch_target    (branch_target),
        .wb_valid         (wb_valid),
        .wb_rd            (wb_rd),
        .wb_data          (wb_data)
    );

    // a lost fetch grant is the only memory stall
    hazard_unit u_hazard (
        .id_rs1              (id_rs1),
        .id_rs2              (id_rs2),
        .opcode              (opcode),
        .ex_rd               (ex_rd),
        .ex_load_inst        (ex_load_inst),
        .jump_branch_taken   (jump_branch_taken),
        .invalid_inst        (invalid_inst),
        .stall               (!fetch_granted),
        .if_id_pipeline_flush(if_id_pipeline_flush),
        .if_id_pipeline_en   (if_id_pipeline_en),
        .id_ex_pipeline_flush(id_ex_pipeline_flush),
        .pc_en               (pc_en),
        .load_stall          (load_stall)
    );

    // the host always wins, so its grant is not needed here
    mem_arbiter u_arbiter (
        .host_req   (host_req),
        .data_req   (data_req),
        .fetch_req  (fetch_req),
        .host_grant (),
        .data_grant (data_grant),
        .fetch_grant(fetch_grant),
        .mem_req    (mem_req)
    );

    unified_mem #(
        .MEM_WORDS(MEM_WORDS)
    ) u_mem (
        .clk    (clk),
        .mem_req(mem_req),
        .rdata  (rdata)
    );

endmodule

`default_nettype wire

// ==== verif/tb_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    import core_pkg::*;
    import mem_pkg::*;

    localparam int VEC_WORDS    = 256;
    localparam int WAIT_LIMIT   = 200;
    localparam int QUIET_CYCLES = 16;

    logic      clk;
    logic      rst_n;
    mem_req_t  host_req;
    mem_word_t rdata;
    logic      wb_valid;
    reg_idx_t  wb_rd;
    xlen_t     wb_data;
    logic      load_stall;

    logic [31:0] vec [VEC_WORDS];
    int          pos;
    int          test_count;
    int          fail_count;
    int          errors;
    logic        stall_seen;

    core_top #(
        .MEM_WORDS(256),
        .RESET_PC (32'h0000_0000)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_req  (host_req),
        .rdata     (rdata),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data),
        .load_stall(load_stall)
    );

    always #20 clk = ~clk;

    // **************************************************
    // stimulus and checking tasks
    // **************************************************

    // every task is entered just after a falling edge and returns just after one

    // the program goes in through the host port while the core sits in reset
    task automatic load_program(input int base, input int n_prog);
        int i;
        rst_n = 1'b0;
        for (i = 0; i < n_prog; i++) begin
            host_req = '{req: 1'b1, we: 1'b1, addr: addr_t'(i * 4), wdata: vec[base + i]};
            @(negedge clk);
        end
        host_req = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic expect_writeback(input int test_id, input reg_idx_t rd, input xlen_t value);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
            if (load_stall) begin
                stall_seen = 1'b1;
            end
            if (wb_valid) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("test %0d: no writeback to x%0d within %0d cycles", test_id, rd, WAIT_LIMIT);
            errors++;
        end else begin
            if (wb_rd !== rd) begin
                $display("FAILED at %0t: wb_rd expected %0d, got %0d", $time, rd, wb_rd);
                errors++;
            end
            if (wb_data !== value) begin
                $display("FAILED at %0t: wb_data expected %08h, got %08h", $time, value, wb_data);
                errors++;
            end
        end
    endtask

    // skipped and invalid instructions must stay silent once the program parks
    task automatic expect_quiet(input int test_id);
        int i;
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            if (load_stall) begin
                stall_seen = 1'b1;
            end
            if (wb_valid) begin
                $display("test %0d: unexpected writeback to x%0d with value %08h",
                         test_id, wb_rd, wb_data);
                errors++;
            end
        end
    endtask

    task automatic host_read_check(input addr_t byte_addr, input mem_word_t value);
        host_req = '{req: 1'b1, we: 1'b0, addr: byte_addr, wdata: '0};
        @(negedge clk);
        if (rdata !== value) begin
            $display("FAILED at %0t: rdata at %08h expected %08h, got %08h",
                     $time, byte_addr, value, rdata);
            errors++;
        end
        host_req = '0;
    endtask

    // each record holds counts, program words, writeback pairs and host read pairs
    task automatic run_test();
        int n_prog;
        int n_wb;
        int n_host;
        int want_stall;
        int base;
        int exp_base;
        int host_base;
        int test_id;
        int i;
        n_prog     = vec[pos];
        n_wb       = vec[pos + 1];
        n_host     = vec[pos + 2];
        want_stall = vec[pos + 3];
        base       = pos + 4;
        exp_base   = base + n_prog;
        host_base  = exp_base + 2 * n_wb;
        test_id    = test_count + 1;
        errors     = 0;
        stall_seen = 1'b0;

        load_program(base, n_prog);
        for (i = 0; i < n_wb; i++) begin
            expect_writeback(test_id, reg_idx_t'(vec[exp_base + 2 * i]),
                             vec[exp_base + 2 * i + 1]);
        end
        expect_quiet(test_id);
        if (want_stall != 0 && !stall_seen) begin
            $display("test %0d: load_stall never went high during the load-use pair", test_id);
            errors++;
        end else if (want_stall == 0 && stall_seen) begin
            $display("test %0d: load_stall went high in a program without a load-use pair",
                     test_id);
            errors++;
        end
        for (i = 0; i < n_host; i++) begin
            host_read_check(vec[host_base + 2 * i], vec[host_base + 2 * i + 1]);
        end

        pos = host_base + 2 * n_host;
        test_count++;
        if (errors == 0) begin
            $display("test %0d: ok, %0d writebacks and %0d host reads matched",
                     test_id, n_wb, n_host);
        end else begin
            fail_count++;
            $display("test %0d: %0d errors", test_id, errors);
        end
    endtask

    // **************************************************
    // main sequence
    // **************************************************

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        host_req   = '0;
        pos        = 0;
        test_count = 0;
        fail_count = 0;
        errors     = 0;
        stall_seen = 1'b0;
        $readmemh("verif/core_vectors.txt", vec);

        @(negedge clk);
        // a record with no program words ends the list
        while (pos < VEC_WORDS - 4 && vec[pos] != 32'd0) begin
            run_test();
        end

        if (test_count == 0) begin
            $display("no test records were found in verif/core_vectors.txt");
        end
        $display("tests run %0d, passed %0d, failed %0d",
                 test_count, test_count - fail_count, fail_count);
        if (test_count > 0 && fail_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/core_vectors.txt ====
// per test, all hex: n_prog n_wb n_host want_load_stall, then program words from address 0,
// then expected (rd value) writebacks in order, then (addr value) host reads; n_prog 0 ends

// dependent alu chain
7 6 0 0
03500093 01C08113 002081B3 40310233 003272B3 0012E333 0000006F
1 00000035 2 00000051 3 00000086 4 FFFFFFCB 5 00000082 6 000000B7

// store, then load and a dependent add
7 5 0 1
20000093 12300113 04000293 0020A023 0000A183 00518233 0000006F
1 00000200 2 00000123 5 00000040 3 00000123 4 00000163

// taken beq and jal each skip two instructions
b 5 0 0
00700093 00700113 00208663 11100193 22200193 0AA00213
00C002EF 33300313 44400313 00128393 0000006F
1 00000007 2 00000007 4 000000AA 5 0000001C 7 0000001D

// untaken bne
6 4 0 0
00300093 00300113 00209463 01008193 02018213 0000006F
1 00000003 2 00000003 3 00000013 4 00000033

// invalid opcode word in the middle
5 3 0 0
05500093 FFFFFFFF 00108113 001101B3 0000006F
1 00000055 2 00000056 3 000000AB

// stores read back through the host port
6 3 2 0
30000093 6A500113 FFE00193 0020A023 0030A223 0000006F
1 00000300 2 000006A5 3 FFFFFFFE
300 000006A5 304 FFFFFFFE

0

// ==== all.f ====
src/core_pkg.sv
src/mem_pkg.sv
src/hazard_unit.sv
src/fetch_unit.sv
src/decode_unit.sv
src/execute_unit.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/core_top.sv
verif/tb_core_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

SOURCES := $(wildcard src/*.sv) $(wildcard verif/*.sv)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
